/* run_sim.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f sources.f --top-module cache_core_tb -o cache_core_tb_sim

# Pass or fail comes from the log
./obj_dir/cache_core_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '^\*\*\* TEST PASSED \*\*\*$' sim.log
then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* sim/cache_checker.sv */
//////////////////////////////////////////////////
// Cache response checker
// Reference model of valid bits, tags and data,
// predicts every response and counts mismatches
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "cache_macros.svh"

module cache_checker (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire cache_pkg::cache_req_t  req_i,
  input  wire logic                   stall_i,
  input  wire logic                   flush_i,
  input  wire logic                   invalidate_i,
  input  wire logic                   fill_i,
  input  wire logic [`CACHE_XLEN-1:0] fill_adr_i,
  input  wire cache_pkg::word_t       fill_d_i,
  input  wire cache_pkg::cache_rsp_t  rsp_i,
  output int                          error_count_o,
  output int                          check_count_o,
  output logic                        busy_o
);

  //////////////////////////////////////////////////
  // Model state
  //////////////////////////////////////////////////

  logic [`CACHE_SETS-1:0]     valid_m;
  cache_pkg::tag_t            tag_m [`CACHE_SETS];
  cache_pkg::word_t           data_m [`CACHE_SETS];
  // Record held in the setup stage
  cache_pkg::cache_req_t      setup_m;
  logic                       setup_valid;
  // Invalidate on its way to lookup, and one parked by a stall
  logic                       inv_pending;
  logic                       inv_held;
  cache_pkg::cache_rsp_t      expected [$];
  cache_pkg::cache_rsp_t      exp_rsp;
  logic [`CACHE_IDX_BITS-1:0] set;
  int                         errors = 0;
  int                         checks = 0;

  assign error_count_o = errors;
  assign check_count_o = checks;

  function automatic logic [`CACHE_IDX_BITS-1:0] set_of(input logic [`CACHE_XLEN-1:0] adr);
    return adr[`CACHE_OFFS_BITS +: `CACHE_IDX_BITS];
  endfunction

  function automatic cache_pkg::tag_t tag_of(input logic [`CACHE_XLEN-1:0] adr);
    return adr[`CACHE_XLEN-1 -: `CACHE_TAG_BITS];
  endfunction

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR: %s", msg);
    errors++;
  endtask

  //////////////////////////////////////////////////
  // Per-edge model step
  //////////////////////////////////////////////////

  always @(posedge clk_i)
  begin
    if (!rst_ni)
    begin
      valid_m     = '0;
      setup_valid = 1'b0;
      inv_pending = 1'b0;
      inv_held    = 1'b0;
      expected.delete();
    end
    else
    begin
      // Ack seen now belongs to the record looked up one edge ago
      if (rsp_i.ack)
      begin
        if (expected.size() == 0)
          report_error("ack arrived with no request in flight");
        else
        begin
          exp_rsp = expected.pop_front();
          compare_field("rsp_o.hit", 32'(rsp_i.hit), 32'(exp_rsp.hit));
          compare_field("rsp_o.we", 32'(rsp_i.we), 32'(exp_rsp.we));
          // Read data only defined on a read hit
          if (exp_rsp.hit && !exp_rsp.we)
            compare_field("rsp_o.q", rsp_i.q, exp_rsp.q);
        end
      end
      else if (expected.size() != 0)
      begin
        report_error("expected ack did not arrive");
        expected.delete();
      end
      // Lookup stage, flush drops the record
      if (!stall_i && !flush_i && setup_valid)
      begin
        set         = set_of(setup_m.adr);
        exp_rsp.ack = 1'b1;
        exp_rsp.we  = setup_m.we;
        exp_rsp.hit = valid_m[set] && (tag_m[set] == tag_of(setup_m.adr));
        exp_rsp.q   = data_m[set];
        expected.push_back(exp_rsp);
        // Write-through on hit only
        if (setup_m.we && exp_rsp.hit)
          data_m[set] = setup_m.d;
      end
      // Invalidate clears first, refill then marks its set
      if (!stall_i && inv_pending)
        valid_m = '0;
      if (fill_i)
      begin
        valid_m[set_of(fill_adr_i)] = 1'b1;
        tag_m[set_of(fill_adr_i)]   = tag_of(fill_adr_i);
        data_m[set_of(fill_adr_i)]  = fill_d_i;
      end
      // Setup stage
      if (flush_i)
        setup_valid = 1'b0;
      else if (!stall_i)
        setup_valid = req_i.req;
      if (!stall_i)
      begin
        setup_m     = req_i;
        inv_pending = invalidate_i | inv_held;
        inv_held    = 1'b0;
      end
      else
        inv_held = invalidate_i | inv_held;
    end
    busy_o = setup_valid || inv_pending || inv_held || (expected.size() != 0);
  end

endmodule

`default_nettype wire

/* sim/cache_core_tb.sv */
//////////////////////////////////////////////////
// Cache core testbench
// Applies a table of fills, reads, writes,
// stalls, flushes and invalidates to the DUT
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "cache_macros.svh"

module cache_core_tb;

  localparam int timeout_cycles = 40;
  localparam int num_rows       = 51;

  // Test addresses, set index in bits 5:2
  localparam logic [31:0] adr_a0 = 32'h0000_1004;
  localparam logic [31:0] adr_a1 = 32'h0000_2004;
  localparam logic [31:0] adr_a2 = 32'h0000_3038;
  localparam logic [31:0] adr_a3 = 32'h0004_0010;
  localparam logic [31:0] adr_a4 = 32'h0000_5020;

  typedef enum logic [2:0] {
    op_idle, op_fill, op_read, op_write, op_inv, op_flush, op_stall, op_rread
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [31:0] adr;
  } row_t;

  //////////////////////////////////////////////////
  // Stimulus table, one row per cycle
  //////////////////////////////////////////////////

  row_t rows [num_rows] = '{
    // Refill, then hit and a miss on another tag in set 1
    '{op_fill, adr_a0}, '{op_fill, adr_a2}, '{op_fill, adr_a3},
    '{op_read, adr_a0}, '{op_read, adr_a1}, '{op_read, adr_a2},
    // Write hit with a forwarded read, a write miss, later reads
    '{op_write, adr_a0}, '{op_read, adr_a0}, '{op_idle, adr_a0},
    '{op_read, adr_a0}, '{op_write, adr_a1}, '{op_read, adr_a0},
    '{op_write, adr_a2}, '{op_read, adr_a2}, '{op_read, adr_a3},
    // Stalls hold a request in setup
    '{op_read, adr_a3}, '{op_stall, adr_a0}, '{op_stall, adr_a0},
    '{op_stall, adr_a0}, '{op_read, adr_a0}, '{op_stall, adr_a0},
    '{op_read, adr_a2},
    // Flush drops stalled and in-flight requests
    '{op_read, adr_a0}, '{op_stall, adr_a0}, '{op_flush, adr_a0},
    '{op_read, adr_a2}, '{op_flush, adr_a0}, '{op_read, adr_a3},
    '{op_read, adr_a0},
    // Invalidate then every filled set misses
    '{op_inv, adr_a0}, '{op_idle, adr_a0}, '{op_read, adr_a0},
    '{op_read, adr_a2}, '{op_read, adr_a3},
    // Refill, then random back-to-back reads
    '{op_fill, adr_a0}, '{op_fill, adr_a2}, '{op_fill, adr_a3},
    '{op_fill, adr_a4}, '{op_rread, adr_a0}, '{op_rread, adr_a0},
    '{op_rread, adr_a0}, '{op_rread, adr_a0}, '{op_rread, adr_a0},
    '{op_rread, adr_a0}, '{op_rread, adr_a0}, '{op_rread, adr_a0},
    '{op_write, adr_a4}, '{op_rread, adr_a0}, '{op_rread, adr_a0},
    '{op_rread, adr_a0}, '{op_rread, adr_a0}
  };

  logic                   clk_i;
  logic                   rst_ni;
  cache_pkg::cache_req_t  req_i;
  logic                   stall_i;
  logic                   flush_i;
  logic                   invalidate_i;
  logic                   fill_i;
  logic [`CACHE_XLEN-1:0] fill_adr_i;
  cache_pkg::word_t       fill_d_i;
  cache_pkg::cache_rsp_t  rsp_o;
  int                     error_count;
  int                     check_count;
  logic                   busy;
  int                     timeouts = 0;
  logic [31:0]            lcg_state = 32'd49142;
  // Addresses refilled since the last invalidate
  logic [31:0]            filled [$];

  cache_core cache_core_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .invalidate_i (invalidate_i),
    .fill_i       (fill_i),
    .fill_adr_i   (fill_adr_i),
    .fill_d_i     (fill_d_i),
    .rsp_o        (rsp_o)
  );

  cache_checker response_check (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .stall_i       (stall_i),
    .flush_i       (flush_i),
    .invalidate_i  (invalidate_i),
    .fill_i        (fill_i),
    .fill_adr_i    (fill_adr_i),
    .fill_d_i      (fill_d_i),
    .rsp_i         (rsp_o),
    .error_count_o (error_count),
    .check_count_o (check_count),
    .busy_o        (busy)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic drive_idle();
    req_i        = '0;
    stall_i      = 1'b0;
    flush_i      = 1'b0;
    invalidate_i = 1'b0;
    fill_i       = 1'b0;
  endtask

  // Idle inputs until the model has nothing in flight
  task automatic wait_until_idle();
    int cycles;
    cycles = 0;
    while (busy && cycles < timeout_cycles)
    begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (busy)
    begin
      $display("ERROR: cache did not drain within %0d cycles", timeout_cycles);
      timeouts++;
    end
  endtask

  // Drive one row for one cycle
  task automatic apply_row(input row_t row);
    int pick;
    drive_idle();
    case (row.op)
      op_fill:
      begin
        fill_i     = 1'b1;
        fill_adr_i = row.adr;
        fill_d_i   = next_rand();
        filled.push_back(row.adr);
      end
      op_read:
      begin
        req_i.req = 1'b1;
        req_i.adr = row.adr;
      end
      op_write:
      begin
        req_i.req = 1'b1;
        req_i.we  = 1'b1;
        req_i.adr = row.adr;
        req_i.d   = next_rand();
      end
      op_inv:
      begin
        invalidate_i = 1'b1;
        filled.delete();
      end
      op_flush:
        flush_i = 1'b1;
      op_stall:
        stall_i = 1'b1;
      op_rread:
      begin
        req_i.req = 1'b1;
        req_i.adr = row.adr;
        // Pick any refilled address
        if (filled.size() != 0)
        begin
          pick      = int'(next_rand() >> 8) % filled.size();
          req_i.adr = filled[pick];
        end
      end
      default:
        ;
    endcase
    @(posedge clk_i);
    #1;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    req_i        = '0;
    stall_i      = 1'b0;
    flush_i      = 1'b0;
    invalidate_i = 1'b0;
    fill_i       = 1'b0;
    fill_adr_i   = '0;
    fill_d_i     = '0;
    rst_ni       = 1'b0;
    repeat (2) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    for (int i = 0; i < num_rows; i++)
    begin
      // Refill and invalidate only into an empty pipeline
      if (rows[i].op == op_fill || rows[i].op == op_inv)
      begin
        drive_idle();
        wait_until_idle();
      end
      apply_row(rows[i]);
    end
    drive_idle();
    wait_until_idle();
    $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeouts);
    if (error_count == 0 && timeouts == 0 && check_count > 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+src
src/cache_pkg.sv
src/cache_setup.sv
src/cache_mem.sv
src/cache_lookup.sv
src/cache_core.sv
sim/cache_checker.sv
sim/cache_core_tb.sv

/* src/cache_core.sv */
//////////////////////////////////////////////////
// Direct-mapped data cache core
// Setup stage, tag and data arrays and lookup
// stage, write-through on hits
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "cache_macros.svh"

module cache_core (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire cache_pkg::cache_req_t  req_i,
  input  wire logic                   stall_i,
  input  wire logic                   flush_i,
  input  wire logic                   invalidate_i,
  input  wire logic                   fill_i,
  input  wire logic [`CACHE_XLEN-1:0] fill_adr_i,
  input  wire cache_pkg::word_t       fill_d_i,
  output cache_pkg::cache_rsp_t       rsp_o
);

  //////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////

  cache_pkg::cache_setup_t    setup;
  logic [`CACHE_IDX_BITS-1:0] idx;
  logic [`CACHE_IDX_BITS-1:0] wadr;
  logic                       tag_we;
  logic                       data_we;
  cache_pkg::tag_t            tag_d;
  cache_pkg::tag_t            tag_q;
  cache_pkg::word_t           data_d;
  cache_pkg::word_t           data_q;

  // Request registration and read index
  cache_setup setup_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .invalidate_i (invalidate_i),
    .req_i        (req_i),
    .setup_o      (setup),
    .idx_o        (idx)
  );

  // Tag array
  cache_mem #(
    .payload_t (cache_pkg::tag_t)
  ) tag_mem (
    .clk_i   (clk_i),
    .we_i    (tag_we),
    .wadr_i  (wadr),
    .radr_i  (idx),
    .d_i     (tag_d),
    .stall_i (stall_i),
    .q_o     (tag_q)
  );

  // Data array
  cache_mem #(
    .payload_t (cache_pkg::word_t)
  ) data_mem (
    .clk_i   (clk_i),
    .we_i    (data_we),
    .wadr_i  (wadr),
    .radr_i  (idx),
    .d_i     (data_d),
    .stall_i (stall_i),
    .q_o     (data_q)
  );

  // Hit detection, forwarding and response
  cache_lookup lookup_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .stall_i    (stall_i),
    .flush_i    (flush_i),
    .fill_i     (fill_i),
    .fill_adr_i (fill_adr_i),
    .fill_d_i   (fill_d_i),
    .setup_i    (setup),
    .tag_i      (tag_q),
    .data_i     (data_q),
    .tag_we_o   (tag_we),
    .data_we_o  (data_we),
    .wadr_o     (wadr),
    .tag_d_o    (tag_d),
    .data_d_o   (data_d),
    .rsp_o      (rsp_o)
  );

endmodule

`default_nettype wire

/* src/cache_lookup.sv */
//////////////////////////////////////////////////
// Cache lookup stage
// Valid bits, tag compare, write-hit forwarding,
// response register and memory write ports
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "cache_macros.svh"

module cache_lookup (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       stall_i,
  input  wire logic                       flush_i,
  input  wire logic                       fill_i,
  input  wire logic [`CACHE_XLEN-1:0]     fill_adr_i,
  input  wire cache_pkg::word_t           fill_d_i,
  input  wire cache_pkg::cache_setup_t    setup_i,
  input  wire cache_pkg::tag_t            tag_i,
  input  wire cache_pkg::word_t           data_i,
  output logic                            tag_we_o,
  output logic                            data_we_o,
  output logic [`CACHE_IDX_BITS-1:0]      wadr_o,
  output cache_pkg::tag_t                 tag_d_o,
  output cache_pkg::word_t                data_d_o,
  output cache_pkg::cache_rsp_t           rsp_o
);

  //////////////////////////////////////////////////
  // Local signals
  //////////////////////////////////////////////////

  logic [`CACHE_SETS-1:0]     valid_q;
  logic [`CACHE_IDX_BITS-1:0] fill_idx;
  logic                       advance;
  logic                       hit;
  logic                       write_hit;
  logic                       fwd_valid;
  logic [`CACHE_IDX_BITS-1:0] fwd_idx;
  cache_pkg::word_t           fwd_word;
  cache_pkg::word_t           rd_word;
  logic                       ack_q;
  logic                       hit_q;
  logic                       we_q;
  cache_pkg::word_t           q_q;

  // Stage moves its record on when not stalled
  assign advance  = !stall_i;
  assign fill_idx = fill_adr_i[`CACHE_OFFS_BITS +: `CACHE_IDX_BITS];

  //////////////////////////////////////////////////
  // Valid bits
  //////////////////////////////////////////////////

  // Invalidate clears all sets, a refill then marks its own set
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      valid_q <= '0;
    else
    begin
      if (advance && setup_i.invalidate)
        valid_q <= '0;
      if (fill_i)
        valid_q[fill_idx] <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Hit and forwarding
  //////////////////////////////////////////////////

  assign hit       = valid_q[setup_i.idx] && (tag_i == setup_i.tag);
  assign write_hit = advance && !flush_i && setup_i.valid && setup_i.we && hit;

  // Array output is stale when the previous record wrote this set
  assign rd_word = (fwd_valid && (fwd_idx == setup_i.idx)) ? fwd_word : data_i;

  // Forward flag lives for exactly one advance
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      fwd_valid <= 1'b0;
    else if (advance)
      fwd_valid <= write_hit;
  end

  // Index and word of the write now landing in the array
  always_ff @(posedge clk_i)
  begin
    if (write_hit)
    begin
      fwd_idx  <= setup_i.idx;
      fwd_word <= setup_i.d;
    end
  end

  //////////////////////////////////////////////////
  // Memory writes
  //////////////////////////////////////////////////

  // Refill writes tag and data, a write hit only data
  assign tag_we_o  = fill_i;
  assign data_we_o = fill_i | write_hit;
  assign wadr_o    = fill_i ? fill_idx : setup_i.idx;
  assign tag_d_o   = fill_adr_i[`CACHE_XLEN-1 -: `CACHE_TAG_BITS];
  assign data_d_o  = fill_i ? fill_d_i : setup_i.d;

  //////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////

  // Ack pulses one cycle per record, flush drops it
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      ack_q <= 1'b0;
    else
      ack_q <= advance && !flush_i && setup_i.valid;
  end

  // Response fields hold under stall
  always_ff @(posedge clk_i)
  begin
    if (advance)
    begin
      hit_q <= hit;
      we_q  <= setup_i.we;
      q_q   <= rd_word;
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.hit = hit_q;
  assign rsp_o.we  = we_q;
  assign rsp_o.q   = q_q;

  // Refill shares the write port, so nothing may be in flight
  fill_idle_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    setup_i.valid |-> !fill_i);

endmodule

`default_nettype wire

/* src/cache_macros.svh */
//////////////////////////////////////////////////
// Cache geometry macros
// Word width, set count and the address split
// into byte offset, set index and tag
//////////////////////////////////////////////////

`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Data word and address width
`define CACHE_XLEN 32

// Number of sets, one way only
`define CACHE_SETS 16

// Byte offset inside a word
`define CACHE_OFFS_BITS 2

// Set index, log2 of CACHE_SETS
`define CACHE_IDX_BITS 4

// Remaining upper address bits
`define CACHE_TAG_BITS 26

`endif

/* src/cache_mem.sv */
//////////////////////////////////////////////////
// Cache memory array
// One write port, one registered read port that
// holds its output under stall
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "cache_macros.svh"

module cache_mem #(
  parameter type payload_t = logic [`CACHE_XLEN-1:0]
) (
  input  wire logic                       clk_i,
  input  wire logic                       we_i,
  input  wire logic [`CACHE_IDX_BITS-1:0] wadr_i,
  input  wire logic [`CACHE_IDX_BITS-1:0] radr_i,
  input  wire payload_t                   d_i,
  input  wire logic                       stall_i,
  output payload_t                        q_o
);

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  // One entry per set
  payload_t mem [`CACHE_SETS];

  // Write lands on the clock edge
  always_ff @(posedge clk_i)
  begin
    if (we_i)
      mem[wadr_i] <= d_i;
  end

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////

  // Read before write on a shared address
  // Lookup forwards the newer word where needed
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
      q_o <= mem[radr_i];
  end

  // A write to an unknown set would corrupt the array
  wadr_known_a : assert property (@(posedge clk_i)
    we_i |-> !$isunknown(wadr_i));

endmodule

`default_nettype wire

/* src/cache_pkg.sv */
//////////////////////////////////////////////////
// Cache types
// Request, setup record and response structs
// shared by the cache pipeline stages
//////////////////////////////////////////////////

`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

  // Tag value as stored in the tag array
  typedef logic [`CACHE_TAG_BITS-1:0] tag_t;

  // One data word as stored in the data array
  typedef logic [`CACHE_XLEN-1:0] word_t;

  // Processor request, full word accesses only
  typedef struct packed {
    logic  req;
    logic  we;
    word_t adr;
    word_t d;
  } cache_req_t;

  // Setup stage output, consumed by the lookup stage
  typedef struct packed {
    logic                       valid;
    logic                       we;
    tag_t                       tag;
    logic [`CACHE_IDX_BITS-1:0] idx;
    word_t                      d;
    logic                       invalidate;
  } cache_setup_t;

  // Response back to the processor
  typedef struct packed {
    logic  ack;
    logic  hit;
    logic  we;
    word_t q;
  } cache_rsp_t;

endpackage

`default_nettype wire

/* src/cache_setup.sv */
//////////////////////////////////////////////////
// Cache address setup stage
// Registers the request controls, holds
// invalidate under stall and drives the memory
// index combinationally
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "cache_macros.svh"

module cache_setup (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       stall_i,
  input  wire logic                       flush_i,
  input  wire logic                       invalidate_i,
  input  wire cache_pkg::cache_req_t      req_i,
  output cache_pkg::cache_setup_t         setup_o,
  output logic [`CACHE_IDX_BITS-1:0]      idx_o
);

  //////////////////////////////////////////////////
  // Local signals
  //////////////////////////////////////////////////

  logic                       flush_dly;
  logic                       invalidate_hold;
  logic                       valid_q;
  logic                       inv_q;
  logic                       we_q;
  cache_pkg::tag_t            tag_q;
  logic [`CACHE_IDX_BITS-1:0] idx_q;
  cache_pkg::word_t           d_q;
  logic [`CACHE_IDX_BITS-1:0] adr_idx;
  logic [`CACHE_IDX_BITS-1:0] adr_idx_dly;

  //////////////////////////////////////////////////
  // Control registers
  //////////////////////////////////////////////////

  // Flush seen last cycle, forces an index reload
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      flush_dly <= 1'b0;
    else
      flush_dly <= flush_i;
  end

  // Collect invalidate pulses that arrive while stalled
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      invalidate_hold <= 1'b0;
    else if (!stall_i)
      invalidate_hold <= 1'b0;
    else
      invalidate_hold <= invalidate_i | invalidate_hold;
  end

  // Request valid, dropped on flush, held under stall
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= 1'b0;
      inv_q   <= 1'b0;
    end
    else
    begin
      if (flush_i)
        valid_q <= 1'b0;
      else if (!stall_i)
        valid_q <= req_i.req;
      // Held invalidate reaches lookup once the stage advances
      if (!stall_i)
        inv_q <= invalidate_i | invalidate_hold;
    end
  end

  // Request payload, only meaningful with valid_q
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      we_q  <= req_i.we;
      tag_q <= req_i.adr[`CACHE_XLEN-1 -: `CACHE_TAG_BITS];
      idx_q <= adr_idx;
      d_q   <= req_i.d;
    end
  end

  assign setup_o.valid      = valid_q;
  assign setup_o.we         = we_q;
  assign setup_o.tag        = tag_q;
  assign setup_o.idx        = idx_q;
  assign setup_o.d          = d_q;
  assign setup_o.invalidate = inv_q;

  //////////////////////////////////////////////////
  // Memory index
  //////////////////////////////////////////////////

  // Live index straight from the request address
  assign adr_idx = req_i.adr[`CACHE_OFFS_BITS +: `CACHE_IDX_BITS];

  // Copy of the index the memories last read
  always_ff @(posedge clk_i)
  begin
    if (!stall_i || flush_dly)
      adr_idx_dly <= adr_idx;
  end

  // Memories register this, so under stall keep the old index
  assign idx_o = (stall_i && !flush_dly) ? adr_idx_dly : adr_idx;

  // Under stall the memories keep reading the set of the held record
  idx_held_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (stall_i && !flush_dly && setup_o.valid) |-> (idx_o == setup_o.idx));

endmodule

`default_nettype wire
